//--- dec_params.svh
// decode pipeline parameters
`ifndef DEC_PARAMS_SVH
`define DEC_PARAMS_SVH

// ************************************************************
// datapath widths
`define DEC_XLEN       32              // data and instruction width
`define DEC_REG_AW     5               // register index width
`define DEC_NREGS      32              // architectural registers, x0 included

// ************************************************************
// program counter
`define DEC_RESET_VEC  32'h0000_1000   // pc of first accepted instruction
`define DEC_PC_STEP    32'd4           // no compressed instructions

// ************************************************************
// major opcodes kept in this core
`define DEC_OPC_OP     7'b0110011      // register-register alu
`define DEC_OPC_OPIMM  7'b0010011      // register-immediate alu
`define DEC_OPC_LUI    7'b0110111      // load upper immediate

`endif

//--- dec_pkg.sv
// decode pipeline types
`default_nettype none
`include "dec_params.svh"

package dec_pkg;

   // alu operation, one per rv32i alu function plus lui
   typedef enum logic [3:0] {
      alu_add,                         // add, addi
      alu_sub,                         // sub only, no subi
      alu_sll,
      alu_slt,                         // signed compare
      alu_sltu,                        // unsigned compare
      alu_xor,
      alu_srl,
      alu_sra,                         // arithmetic shift, sign fill
      alu_or,
      alu_and,
      alu_passb                        // lui, b operand straight out
   } dec_alu_op_e;

   // ************************************************************
   // buffered instruction, ib to decode
   typedef struct packed {
      logic [`DEC_XLEN-1:0]   pc;
      logic [`DEC_XLEN-1:0]   insn;
   } dec_fetch_t;

   // decoded instruction, decode to exec
   typedef struct packed {
      logic [`DEC_XLEN-1:0]   pc;
      logic [`DEC_XLEN-1:0]   insn;
      logic [`DEC_REG_AW-1:0] rs1;
      logic [`DEC_REG_AW-1:0] rs2;
      logic [`DEC_REG_AW-1:0] rd;     // zero when illegal
      logic                   wen;    // gpr write enable
      logic [`DEC_XLEN-1:0]   imm;    // sign extended i or u immediate
      logic                   use_imm; // imm replaces rs2 operand
      dec_alu_op_e            alu_op;
      logic                   illegal;
   } dec_pkt_t;

   // retire record, also the write-back source
   typedef struct packed {
      logic [`DEC_XLEN-1:0]   pc;
      logic [`DEC_XLEN-1:0]   insn;
      logic [`DEC_REG_AW-1:0] rd;
      logic [`DEC_XLEN-1:0]   wdata;
      logic                   exception; // illegal instruction
   } dec_trace_t;

endpackage

`default_nettype wire

//--- dec_stage_if.sv
// stage to stage handshake
`default_nettype none

// valid/ready link between two pipeline stages
// transfer on clk edge with valid and ready both high
interface dec_stage_if #(
   parameter type payload_t = logic    // set per instance
) ();

   logic     valid;                    // payload holds until taken
   logic     ready;                    // sink can take this cycle
   payload_t payload;

   // producer side
   modport src (
      output valid,
      output payload,
      input  ready
   );

   // consumer side
   modport dst (
      input  valid,
      input  payload,
      output ready
   );

endinterface

`default_nettype wire

//--- dec_ib.sv
// instruction buffer
`default_nettype none
`include "dec_params.svh"

module dec_ib import dec_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                instr_valid,
   output logic                instr_ready,
   input  logic [`DEC_XLEN-1:0] instr,
   dec_stage_if.src            fetch
);

   dec_fetch_t           mem [2];      // two entry fifo
   logic                 wr_ptr;
   logic                 rd_ptr;
   logic [1:0]           count;        // 0..2 entries
   logic [`DEC_XLEN-1:0] pc_q;         // pc of next accepted instr
   logic                 push;
   logic                 pop;

   assign instr_ready   = (count != 2'd2);             // full blocks input
   assign push          = instr_valid & instr_ready;
   assign fetch.valid   = (count != 2'd0);
   assign fetch.payload = mem[rd_ptr];                 // oldest entry
   assign pop           = fetch.valid & fetch.ready;

   // pointers, occupancy and pc counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
         pc_q   <= `DEC_RESET_VEC;
      end else begin
         if (push) begin
            wr_ptr <= ~wr_ptr;
            pc_q   <= pc_q + `DEC_PC_STEP;            // sequential only
         end
         if (pop) rd_ptr <= ~rd_ptr;
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;                   // none or both
         endcase
      end
   end

   // entry storage, payload only
   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= '{pc: pc_q, insn: instr};
   end

endmodule

`default_nettype wire

//--- dec_decode.sv
// instruction decode stage
`default_nettype none
`include "dec_params.svh"

module dec_decode import dec_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   dec_stage_if.dst fetch,
   dec_stage_if.src dec
);

   localparam logic [6:0] F7_BASE = 7'b0000000;   // add, srl and friends
   localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub, sra

   dec_fetch_t fin;
   dec_pkt_t   pkt_d;                  // combinational decode
   dec_pkt_t   pkt_q;                  // output register
   logic       valid_q;
   logic       take;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   // funct3 to alu op for the base encodings
   function automatic dec_alu_op_e base_op(input logic [2:0] f3);
      case (f3)
         3'b000:  return alu_add;
         3'b001:  return alu_sll;
         3'b010:  return alu_slt;
         3'b011:  return alu_sltu;
         3'b100:  return alu_xor;
         3'b101:  return alu_srl;
         3'b110:  return alu_or;
         default: return alu_and;
      endcase
   endfunction

   assign fin    = fetch.payload;
   assign opcode = fin.insn[6:0];
   assign funct3 = fin.insn[14:12];
   assign funct7 = fin.insn[31:25];

   // ************************************************************
   // field split, immediates, alu op, legality
   always_comb begin
      pkt_d         = '0;
      pkt_d.pc      = fin.pc;
      pkt_d.insn    = fin.insn;
      pkt_d.rs1     = fin.insn[19:15];
      pkt_d.rs2     = fin.insn[24:20];
      pkt_d.rd      = fin.insn[11:7];
      pkt_d.wen     = 1'b1;
      pkt_d.imm     = {{(`DEC_XLEN-12){fin.insn[31]}}, fin.insn[31:20]}; // i-type
      pkt_d.alu_op  = base_op(funct3);
      case (opcode)
         `DEC_OPC_OP: begin
            if (funct7 == F7_ALT) begin
               if (funct3 == 3'b000)      pkt_d.alu_op = alu_sub;
               else if (funct3 == 3'b101) pkt_d.alu_op = alu_sra;
               else                       pkt_d.illegal = 1'b1; // no alt form
            end else if (funct7 != F7_BASE) begin
               pkt_d.illegal = 1'b1;                           // m ext etc
            end
         end
         `DEC_OPC_OPIMM: begin
            pkt_d.use_imm = 1'b1;
            if (funct3 == 3'b001 && funct7 != F7_BASE) begin
               pkt_d.illegal = 1'b1;                           // bad slli
            end else if (funct3 == 3'b101) begin
               if (funct7 == F7_ALT)       pkt_d.alu_op  = alu_sra;  // srai
               else if (funct7 != F7_BASE) pkt_d.illegal = 1'b1;
            end
         end
         `DEC_OPC_LUI: begin
            pkt_d.use_imm = 1'b1;
            pkt_d.imm     = {fin.insn[31:12], 12'b0};          // u-type
            pkt_d.alu_op  = alu_passb;
         end
         default: pkt_d.illegal = 1'b1;                        // loads, branches...
      endcase
      if (pkt_d.illegal) begin
         pkt_d.wen = 1'b0;                                     // no arch update
         pkt_d.rd  = '0;
      end
   end

   // ************************************************************
   // output register, holds while downstream stalls
   assign fetch.ready = ~valid_q | dec.ready;   // empty or leaving now
   assign take        = fetch.valid & fetch.ready;
   assign dec.valid   = valid_q;
   assign dec.payload = pkt_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)         valid_q <= 1'b0;
      else if (take)      valid_q <= 1'b1;
      else if (dec.ready) valid_q <= 1'b0;     // taken, nothing behind
   end

   always_ff @(posedge clk) begin
      if (take) pkt_q <= pkt_d;
   end

endmodule

`default_nettype wire

//--- dec_gpr.sv
// integer register file
`default_nettype none
`include "dec_params.svh"

module dec_gpr (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`DEC_REG_AW-1:0] raddr0,
   input  logic [`DEC_REG_AW-1:0] raddr1,
   output logic [`DEC_XLEN-1:0]   rdata0,
   output logic [`DEC_XLEN-1:0]   rdata1,
   input  logic                  wen,
   input  logic [`DEC_REG_AW-1:0] waddr,
   input  logic [`DEC_XLEN-1:0]   wdata
);

   logic [`DEC_XLEN-1:0] regs [1:`DEC_NREGS-1];  // x0 not stored

   // read ports, x0 hardwired to zero
   // no write-through, exec bypasses the retiring value
   assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
   assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

   // single write port
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < `DEC_NREGS; i++) begin
            regs[i] <= '0;                        // all-zero start state
         end
      end else if (wen && waddr != '0) begin
         regs[waddr] <= wdata;                    // x0 writes dropped
      end
   end

endmodule

`default_nettype wire

//--- dec_exec.sv
// execute and retire stage
`default_nettype none
`include "dec_params.svh"

module dec_exec import dec_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   dec_stage_if.dst dec,
   output logic     trace_valid,
   input  logic     trace_ready,
   output dec_trace_t trace
);

   dec_pkt_t             pkt;
   dec_trace_t           ret_q;        // retire register
   logic                 ret_valid;
   logic                 ret_wen;      // retiring instr writes gpr
   logic                 take;
   logic                 retire;       // trace handshake this cycle
   logic [`DEC_XLEN-1:0] gpr_a;
   logic [`DEC_XLEN-1:0] gpr_b;
   logic [`DEC_XLEN-1:0] op_a;
   logic [`DEC_XLEN-1:0] rs2_val;
   logic [`DEC_XLEN-1:0] op_b;
   logic [4:0]           shamt;
   logic [`DEC_XLEN-1:0] alu_res;
   logic                 byp_ok;       // retire reg holds a pending write

   assign pkt       = dec.payload;
   assign retire    = ret_valid & trace_ready;
   assign dec.ready = ~ret_valid | trace_ready;
   assign take      = dec.valid & dec.ready;

   dec_gpr gpr_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .raddr0 (pkt.rs1),
      .raddr1 (pkt.rs2),
      .rdata0 (gpr_a),
      .rdata1 (gpr_b),
      .wen    (retire & ret_wen),          // written as it leaves
      .waddr  (ret_q.rd),
      .wdata  (ret_q.wdata)
   );

   // ************************************************************
   // operand select with bypass from retire reg
   assign byp_ok  = ret_valid & ret_wen & (ret_q.rd != '0);
   assign op_a    = (byp_ok && ret_q.rd == pkt.rs1) ? ret_q.wdata : gpr_a;
   assign rs2_val = (byp_ok && ret_q.rd == pkt.rs2) ? ret_q.wdata : gpr_b;
   assign op_b    = pkt.use_imm ? pkt.imm : rs2_val;
   assign shamt   = op_b[4:0];                    // rv32 shift range

   always_comb begin
      case (pkt.alu_op)
         alu_add:   alu_res = op_a + op_b;
         alu_sub:   alu_res = op_a - op_b;
         alu_sll:   alu_res = op_a << shamt;
         alu_slt:   alu_res = {{(`DEC_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         alu_sltu:  alu_res = {{(`DEC_XLEN-1){1'b0}}, op_a < op_b};
         alu_xor:   alu_res = op_a ^ op_b;
         alu_srl:   alu_res = op_a >> shamt;
         alu_sra:   alu_res = $unsigned($signed(op_a) >>> shamt);
         alu_or:    alu_res = op_a | op_b;
         alu_and:   alu_res = op_a & op_b;
         alu_passb: alu_res = op_b;                 // lui
         default:   alu_res = '0;
      endcase
   end

   // ************************************************************
   // retire register, feeds trace and gpr write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ret_valid <= 1'b0;
         ret_wen   <= 1'b0;
      end else if (take) begin
         ret_valid <= 1'b1;
         ret_wen   <= pkt.wen;                      // cleared for illegal
      end else if (trace_ready) begin
         ret_valid <= 1'b0;                         // drained
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         ret_q.pc        <= pkt.pc;
         ret_q.insn      <= pkt.insn;
         ret_q.rd        <= pkt.rd;
         ret_q.wdata     <= pkt.illegal ? '0 : alu_res;
         ret_q.exception <= pkt.illegal;
      end
   end

   assign trace_valid = ret_valid;
   assign trace       = ret_q;

endmodule

`default_nettype wire

//--- dec_top.sv
// decode pipeline top
`default_nettype none
`include "dec_params.svh"

module dec_top import dec_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  instr_valid,
   output logic                  instr_ready,
   input  logic [`DEC_XLEN-1:0]   instr,
   output logic                  trace_valid,
   input  logic                  trace_ready,
   output logic [`DEC_XLEN-1:0]   trace_pc,
   output logic [`DEC_XLEN-1:0]   trace_insn,
   output logic [`DEC_REG_AW-1:0] trace_rd,
   output logic [`DEC_XLEN-1:0]   trace_wdata,
   output logic                  trace_exception
);

   dec_trace_t trace;                  // retire record from exec

   dec_stage_if #(.payload_t(dec_fetch_t)) fetch_if ();   // ib -> decode
   dec_stage_if #(.payload_t(dec_pkt_t))   dec_if ();     // decode -> exec

   dec_ib ib_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .instr       (instr),
      .fetch       (fetch_if.src)
   );

   dec_decode decode_inst (.clk(clk), .rst_n(rst_n), .fetch(fetch_if.dst), .dec(dec_if.src));

   dec_exec exec_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .dec         (dec_if.dst),
      .trace_valid (trace_valid),
      .trace_ready (trace_ready),
      .trace       (trace)
   );

   // trace record onto flat ports
   assign trace_pc        = trace.pc;
   assign trace_insn      = trace.insn;
   assign trace_rd        = trace.rd;
   assign trace_wdata     = trace.wdata;
   assign trace_exception = trace.exception;

endmodule

`default_nettype wire

//--- dec_tb_assert.sv
// retire handshake assertions
`default_nettype none
`include "dec_params.svh"

module dec_tb_assert import dec_pkg::*; (
   input logic       clk,
   input logic       rst_n,
   input logic       trace_valid,
   input logic       trace_ready,
   input dec_trace_t trace
);

   // nothing retires while reset is held
   reset_idle: assert property (@(posedge clk) !rst_n |-> !trace_valid)
      else $error("trace_valid high while reset is asserted");

   // ************************************************************
   // stalled record holds until the consumer takes it
   hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      trace_valid && !trace_ready |=> trace_valid && $stable(trace))
      else $error("trace record changed or dropped while stalled");

endmodule

bind dec_exec dec_tb_assert exec_assert_inst (
   .clk         (clk),
   .rst_n       (rst_n),
   .trace_valid (trace_valid),
   .trace_ready (trace_ready),
   .trace       (trace)
);

`default_nettype wire

//--- dec_tb.sv
// decode pipeline testbench
`default_nettype none
`include "dec_params.svh"

module dec_tb import dec_pkg::*; ();

   logic                   clk;
   logic                   rst_n;
   logic                   instr_valid;
   logic                   instr_ready;
   logic [`DEC_XLEN-1:0]   instr;
   logic                   trace_valid;
   logic                   trace_ready;
   logic [`DEC_XLEN-1:0]   trace_pc;
   logic [`DEC_XLEN-1:0]   trace_insn;
   logic [`DEC_REG_AW-1:0] trace_rd;
   logic [`DEC_XLEN-1:0]   trace_wdata;
   logic                   trace_exception;

   logic [`DEC_XLEN-1:0]   exp_insn [$];    // one entry per instruction
   logic [`DEC_REG_AW-1:0] exp_rd [$];
   logic [`DEC_XLEN-1:0]   exp_wdata [$];
   logic                   exp_exc [$];
   int                     n_insn;
   logic                   loaded;          // set once vectors are read
   logic [31:0]            lfsr_q;

   dec_top dec_top_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .instr_valid     (instr_valid),
      .instr_ready     (instr_ready),
      .instr           (instr),
      .trace_valid     (trace_valid),
      .trace_ready     (trace_ready),
      .trace_pc        (trace_pc),
      .trace_insn      (trace_insn),
      .trace_rd        (trace_rd),
      .trace_wdata     (trace_wdata),
      .trace_exception (trace_exception)
   );

   // ************************************************************
   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic take_bit();
      lfsr_q = lfsr_step(lfsr_q);                    // one step per bit
      return lfsr_q[0];
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [`DEC_XLEN-1:0] got,
                             input logic [`DEC_XLEN-1:0] exp);
      if (got !== exp) stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_index(input string name, input logic [`DEC_REG_AW-1:0] got,
                              input logic [`DEC_REG_AW-1:0] exp);
      if (got !== exp) stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   // insn rd wdata exception on each line
   task automatic load_vectors();
      int          fd;
      string       line;
      logic [31:0] f_insn, f_rd, f_wdata, f_exc;
      fd = $fopen("dec_input.txt", "r");
      if (fd == 0) begin
         stop_run("cannot open dec_input.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %h", f_insn, f_rd, f_wdata, f_exc) == 4) begin
               exp_insn.push_back(f_insn);
               exp_rd.push_back(f_rd[`DEC_REG_AW-1:0]);
               exp_wdata.push_back(f_wdata);
               exp_exc.push_back(f_exc[0]);
            end                                     // header lines skipped
         end
         $fclose(fd);
         n_insn = exp_insn.size();
         if (n_insn == 0) stop_run("no instructions found in dec_input.txt");
      end
   endtask

   // ************************************************************
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;                        // period 100
   end

   // reset then random input gaps and trace stalls
   initial begin : stimulus
      int idx;
      idx         = 0;
      lfsr_q      = 32'h6892ce71;
      loaded      = 1'b0;
      rst_n       <= 1'b0;
      instr_valid <= 1'b0;
      instr       <= '0;
      trace_ready <= 1'b0;
      load_vectors();
      loaded = 1'b1;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      forever begin
         @(posedge clk);
         if (instr_valid && instr_ready) idx = idx + 1;   // taken at this edge
         if (!instr_valid || instr_ready) begin           // free to change
            if (idx < n_insn && !(take_bit() & take_bit())) begin
               instr_valid <= 1'b1;
               instr       <= exp_insn[idx];
            end else begin
               instr_valid <= 1'b0;                        // gap or done
            end
         end
         trace_ready <= ~(take_bit() & take_bit());        // stall about 1 in 4
      end
   end

   // in-order retire check with pc from index
   initial begin : retire_check
      int                   n_ret;
      int                   extra;
      logic [`DEC_XLEN-1:0] exp_pc;
      n_ret = 0;
      extra = 0;
      wait (loaded);
      while (n_ret < n_insn) begin
         @(posedge clk);
         if (rst_n && trace_valid && trace_ready) begin
            exp_pc = `DEC_RESET_VEC + `DEC_PC_STEP * n_ret;
            check_word("trace_pc", trace_pc, exp_pc);
            check_word("trace_insn", trace_insn, exp_insn[n_ret]);
            check_index("trace_rd", trace_rd, exp_rd[n_ret]);
            check_word("trace_wdata", trace_wdata, exp_wdata[n_ret]);
            check_flag("trace_exception", trace_exception, exp_exc[n_ret]);
            n_ret = n_ret + 1;
         end
      end
      repeat (10) begin
         @(posedge clk);
         if (trace_valid) extra = extra + 1;               // duplicates show here
      end
      if (extra != 0) begin
         stop_run("trace record seen after the last instruction retired");
      end else begin
         $display("sim passed");
         $finish;
      end
   end

   initial begin : watchdog
      wait (loaded);
      repeat (n_insn * 40 + 100) @(posedge clk);
      stop_run("watchdog expired before every instruction retired");
   end

endmodule

`default_nettype wire

//--- dec_input.txt
// insn     rd  wdata     exc   all hex, one instruction per line
// expected values follow rv32i in order from an all-zero register file
00500093 01 00000005 0
ffd08113 02 00000002 0
0f014193 03 000000f2 0
7001e213 04 000007f2 0
0ff27293 05 000000f2 0
fff12313 06 00000000 0
fff13393 07 00000001 0
00409413 08 00000050 0
800004b7 09 80000000 0
4044d513 0a f8000000 0
00208633 0c 00000007 0
401606b3 0d 00000002 0
00169733 0e 00000040 0
00e527b3 0f 00000001 0
00e53833 10 00000000 0
00708013 00 0000000c 0
00100933 12 00000005 0
00112023 00 00000000 1
00208463 00 00000000 1
021080b3 00 00000000 1
00008a33 14 00000005 0
40d55ab3 15 fe000000 0

//--- all.f
+incdir+.
dec_pkg.sv
dec_stage_if.sv
dec_ib.sv
dec_decode.sv
dec_gpr.sv
dec_exec.sv
dec_top.sv
dec_tb_assert.sv
dec_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode pipeline testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module dec_tb -f all.f -o Vdec_tb

# pass only if the testbench printed its pass line
out=$(./obj_dir/Vdec_tb || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "sim passed"
